//--- list.f
verilog/control_pkg.sv
verilog/ir_decoder.sv
verilog/branch_cond.sv
verilog/sequencer.sv
verilog/datapath_ctrl.sv
verilog/bus_ctrl.sv
verilog/control_top.sv
verif/control_asserts.sv
verif/control_tb.sv

//--- run.sh
#!/bin/sh
# build and run the control unit testbench, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module control_tb -o control_sim -f list.f \
    || exit 1
./obj_dir/control_sim +verilator+error+limit+1000 | tee /dev/stderr \
    | grep "ALL TESTS PASSED" > /dev/null && exit 0 || exit 1

//--- verif/control_asserts.sv
`timescale 1ns/1ps

module control_asserts (
    input logic                  clk_i,
    input logic                  rst_i,
    input control_pkg::instr_t   ir,
    input control_pkg::ccr_t     ccr,
    input logic                  supervisor,
    input logic                  bus_ack,
    input control_pkg::align_t   bus_align,
    input control_pkg::dp_ctrl_t ctrl,
    input control_pkg::bus_req_t bus,
    input control_pkg::exc_t     exception,
    input logic                  halt
);
    import control_pkg::*;

    int         fail_count = 0;
    bus_req_t   prev_bus;
    pc_sel_t    prev_pcsel;
    logic       prev_hold;   // bus waited without ack last cycle
    logic       prev_cyc;
    logic       seen_bus;
    logic [2:0] next_hist;   // pcsel == PC_NEXT, one to three cycles back
    logic [1:0] exc_left;    // bus cycles still owed by an exception entry
    logic       bus_start;
    logic       exc_due;
    logic       is_bad_type;
    logic       is_exc_op;
    logic       is_ldst;
    logic       is_branch;
    logic       is_halt_op;
    logic       quiet;
    logic       exp_taken;
    byte_en_t   exp_lanes;
    exc_t       exp_exc;

    assign bus_start   = bus.cyc && !prev_cyc;
    assign is_bad_type = !(ir[31:28] inside {T_INH, T_ALU, T_LDI, T_LOAD, T_STORE,
                                             T_BRANCH, T_JUMP});
    assign is_exc_op   = (ir[31:28] == T_INH) && !ir[0] &&
                         ((ir[27:24] == 4'h1) || ((ir[27:24] == 4'h4) && !supervisor));
    // bad type traps in decode, trap and halt one cycle later
    assign exc_due     = (next_hist[1] && is_bad_type) || (next_hist[2] && is_exc_op);
    assign is_ldst     = (ir[31:28] == T_LOAD) || (ir[31:28] == T_STORE);
    assign is_branch   = (ir[31:28] == T_BRANCH);
    assign is_halt_op  = (ir[31:28] == T_INH) && (ir[27:24] == 4'h4);
    assign quiet       = !halt && !bus.cyc && !ctrl.ir_write && !ctrl.a_write &&
                         !ctrl.b_write && (ctrl.reg_write == REG_WRITE_NONE) &&
                         (exception == EXC_RESET);
    assign exp_exc     = ((ir[31:28] == T_INH) && (ir[27:24] == 4'h1)) ?
                         {EXC_TRAP_BASE[3:2], ir[2:1]} : EXC_ILLOP;

    always_comb begin
        case (ir[27:24])  // ccr is {ltu, lt, eq}
            4'd0:    exp_taken = 1'b1;
            4'd1:    exp_taken = ccr[0];
            4'd2:    exp_taken = !ccr[0];
            4'd3:    exp_taken = !ccr[2] && !ccr[0];
            4'd4:    exp_taken = !ccr[1] && !ccr[0];
            4'd5:    exp_taken = !ccr[1];
            4'd6:    exp_taken = ccr[1] || ccr[0];
            4'd7:    exp_taken = ccr[1];
            4'd8:    exp_taken = !ccr[2];
            4'd9:    exp_taken = ccr[2];
            4'd10:   exp_taken = ccr[2] || ccr[0];
            default: exp_taken = 1'b0;
        endcase
    end

    always_comb begin
        exp_lanes = 4'b1111;
        if (bus.addrsel == ADDR_MAR && is_ldst) begin
            if (ir[25:24] == 2'd1) begin
                exp_lanes = bus_align[1] ? 4'b0011 : 4'b1100;
            end else if (ir[25:24] == 2'd2) begin
                case (bus_align)
                    2'd0:    exp_lanes = 4'b1000;
                    2'd1:    exp_lanes = 4'b0100;
                    2'd2:    exp_lanes = 4'b0010;
                    default: exp_lanes = 4'b0001;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            prev_bus   <= '0;
            prev_pcsel <= PC_PC;
            prev_hold  <= 1'b0;
            prev_cyc   <= 1'b0;
            seen_bus   <= 1'b0;
            next_hist  <= '0;
            exc_left   <= '0;
        end else begin
            prev_bus   <= bus;
            prev_pcsel <= ctrl.pcsel;
            prev_hold  <= bus.cyc && !bus_ack;
            prev_cyc   <= bus.cyc;
            next_hist  <= {next_hist[1:0], ctrl.pcsel == PC_NEXT};
            if (bus.cyc)
                seen_bus <= 1'b1;
            if (exc_due)
                exc_left <= 2'd3;
            else if (bus_start && exc_left != 2'd0)
                exc_left <= exc_left - 2'd1;
        end
    end

    // covers the reset cycles and the first one after
    a_reset_quiet: assert property (@(posedge clk_i) (rst_i || $past(rst_i)) |-> quiet)
        else begin
            fail_count++;
            $error("CHECK FAILED reset outputs ctrl %h bus %h exception %h halt %h",
                   ctrl, bus, exception, halt);
        end

    a_first_bus: assert property (@(posedge clk_i) disable iff (rst_i)
        (bus.cyc && !seen_bus) |-> (!bus.write && prev_pcsel == PC_EXC))
        else begin
            fail_count++;
            $error("CHECK FAILED first bus cycle write %h prev pcsel %h", bus.write,
                   prev_pcsel);
        end

    a_bus_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        prev_hold |-> (bus == prev_bus))
        else begin
            fail_count++;
            $error("CHECK FAILED bus expected %h got %h", prev_bus, bus);
        end

    a_lanes: assert property (@(posedge clk_i) disable iff (rst_i)
        bus.cyc |-> (bus.byteenable == exp_lanes))
        else begin
            fail_count++;
            $error("CHECK FAILED bus.byteenable expected %h got %h", exp_lanes,
                   bus.byteenable);
        end

    a_branch: assert property (@(posedge clk_i) disable iff (rst_i)
        (next_hist[1] && is_branch && !ir[0]) |->
        (ctrl.pcsel == (exp_taken ? PC_REL : PC_PC)))
        else begin
            fail_count++;
            $error("CHECK FAILED ctrl.pcsel taken %h got %h", exp_taken, ctrl.pcsel);
        end

    a_exc_code: assert property (@(posedge clk_i) disable iff (rst_i)
        exc_due |-> (exception == exp_exc))
        else begin
            fail_count++;
            $error("CHECK FAILED exception expected %h got %h", exp_exc, exception);
        end

    // write pc, write ccr, read vector
    a_exc_bus: assert property (@(posedge clk_i) disable iff (rst_i)
        (bus_start && exc_left != 2'd0) |-> (bus.write == (exc_left != 2'd1)))
        else begin
            fail_count++;
            $error("CHECK FAILED bus.write on exception entry, %h left, got %h",
                   exc_left, bus.write);
        end

    a_halt_rise: assert property (@(posedge clk_i) disable iff (rst_i)
        (next_hist[2] && is_halt_op && supervisor && !ir[0]) |-> halt)
        else begin
            fail_count++;
            $error("CHECK FAILED halt expected 1 got %h", halt);
        end

    a_halt_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        halt |=> (halt && !bus.cyc))
        else begin
            fail_count++;
            $error("CHECK FAILED after halt halt %h bus.cyc %h", halt, bus.cyc);
        end

endmodule

//--- verif/control_tb.sv
`timescale 1ns/1ps

module control_tb;
    import control_pkg::*;

    localparam int CLK_PERIOD = 10;

    logic       clk_i;
    logic       rst_i;
    instr_t     ir = '0;
    ccr_t       ccr = '0;
    logic       supervisor = 1'b1;
    logic       bus_ack = 1'b0;
    align_t     bus_align = '0;
    dp_ctrl_t   ctrl;
    bus_req_t   bus;
    exc_t       exception;
    logic       halt;

    int         seed = 32'he1db;
    int         prog_len = 0;
    int         pc_idx = 0;
    logic [1:0] ack_delay = 2'd0;
    logic       prog_ready;
    instr_t     prog_word [$];
    logic       prog_super [$];

    control_top i_dut (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .ir         (ir),
        .ccr        (ccr),
        .supervisor (supervisor),
        .bus_ack    (bus_ack),
        .bus_align  (bus_align),
        .ctrl       (ctrl),
        .bus        (bus),
        .exception  (exception),
        .halt       (halt)
    );

    bind control_top control_asserts i_asserts (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .ir         (ir),
        .ccr        (ccr),
        .supervisor (supervisor),
        .bus_ack    (bus_ack),
        .bus_align  (bus_align),
        .ctrl       (ctrl),
        .bus        (bus),
        .exception  (exception),
        .halt       (halt)
    );

    function automatic logic [3:0] random_nibble();
        int rnd;
        rnd = $random(seed);
        return rnd[3:0];
    endfunction

    // registers and immediate bits are random, type, op and size are fixed
    task automatic add_instr(logic [3:0] itype, logic [3:0] op, logic size, logic sup);
        instr_t w;
        w = $random(seed);
        w[31:28] = itype;
        w[27:24] = op;
        w[0] = size;
        prog_word.push_back(w);
        prog_super.push_back(sup);
    endtask

    task automatic build_program();
        add_instr(T_INH, INH_NOP, 1'b0, 1'b1);
        for (int i = 0; i < 4; i++) begin
            add_instr(T_ALU, random_nibble(), 1'b0, 1'b1);
        end
        add_instr(T_LDI, random_nibble(), 1'b0, 1'b1);
        add_instr(T_LDI, random_nibble(), 1'b1, 1'b1);
        for (int i = 0; i < 6; i++) begin
            // low op bits walk word, halfword and byte
            add_instr(T_LOAD, (random_nibble() & 4'hc) | {2'b00, i[1:0]}, i[0], 1'b1);
            add_instr(T_STORE, (random_nibble() & 4'hc) | {2'b00, i[2:1]}, i[1], 1'b1);
        end
        for (int i = 0; i < 16; i++) begin
            add_instr(T_BRANCH, i[3:0], 1'b0, 1'b1); // every op, never-taken ones too
        end
        add_instr(T_JUMP, random_nibble(), 1'b0, 1'b1);
        add_instr(T_JUMP, random_nibble(), 1'b1, 1'b1);
        add_instr(T_INH, INH_HALT, 1'b0, 1'b0);
        add_instr(T_INH, INH_TRAP, 1'b0, 1'b1);
        add_instr(4'h5, random_nibble(), 1'b0, 1'b1);
        add_instr(T_INH, INH_HALT, 1'b0, 1'b1);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // bus slave with random wait states, plus the instruction register model
    always @(posedge clk_i) begin
        int rnd;
        if (rst_i) begin
            bus_ack <= 1'b0;
        end else if (bus_ack) begin
            rnd = $random(seed);
            bus_ack   <= 1'b0;
            ack_delay <= rnd[6:5];
            if (ctrl.ir_write && pc_idx < prog_len) begin
                ir         <= prog_word[pc_idx];
                supervisor <= prog_super[pc_idx];
                ccr        <= rnd[2:0];
                bus_align  <= rnd[4:3];
                pc_idx     <= pc_idx + 1;
            end
        end else if (bus.cyc) begin
            if (ack_delay == 2'd0)
                bus_ack <= 1'b1;
            else
                ack_delay <= ack_delay - 2'd1;
        end else begin
            rnd = $random(seed);
            ack_delay <= rnd[1:0];
        end
    end

    initial begin
        rst_i = 1'b1;
        build_program();
        prog_len   = prog_word.size();
        prog_ready = 1'b1;
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        wait (halt === 1'b1);
        repeat (10) @(posedge clk_i); // halted, bus must stay idle
        $display("assertion failures: %0d", i_dut.i_asserts.fail_count);
        if (i_dut.i_asserts.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        wait (prog_ready === 1'b1);
        repeat (40 * prog_len + 200) @(posedge clk_i);
        $display("timeout: the program did not reach halt within %0d cycles",
                 40 * prog_len + 200);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- verilog/branch_cond.sv
`timescale 1ns/1ps

module branch_cond (
    input  control_pkg::ir_fields_t fields,
    input  control_pkg::ccr_t       ccr,
    output logic                    taken
);
    logic ltu;
    logic lt;
    logic eq;

    assign {ltu, lt, eq} = ccr;

    always_comb begin
        case (fields.op)
            4'h0:    taken = 1'b1;        // bra
            4'h1:    taken = eq;
            4'h2:    taken = !eq;
            4'h3:    taken = !(ltu || eq); // gtu
            4'h4:    taken = !(lt || eq);
            4'h5:    taken = !lt;
            4'h6:    taken = lt || eq;
            4'h7:    taken = lt;
            4'h8:    taken = !ltu;         // geu
            4'h9:    taken = ltu;
            4'ha:    taken = ltu || eq;
            default: taken = 1'b0;         // brn
        endcase
    end

endmodule

//--- verilog/bus_ctrl.sv
`timescale 1ns/1ps

module bus_ctrl (
    input  control_pkg::state_t     state,
    input  control_pkg::ir_fields_t fields,
    input  control_pkg::align_t     bus_align,
    output control_pkg::bus_req_t   bus
);
    import control_pkg::*;

    byte_en_t lanes;

    always_comb begin
        case (fields.op[1:0])
            2'h1:    lanes = bus_align[1] ? 4'b0011 : 4'b1100; // halfword
            2'h2:    lanes = 4'b1000 >> bus_align;            // byte
            default: lanes = 4'b1111;
        endcase
    end

    always_comb begin
        bus.cyc        = 1'b0;
        bus.write      = 1'b0;
        bus.addrsel    = ADDR_PC;
        bus.byteenable = 4'b1111;
        case (state)
            S_FETCH,
            S_ARG,
            S_EXC11: bus.cyc = 1'b1;
            S_EXC5,
            S_EXC9: begin
                bus.cyc     = 1'b1;
                bus.write   = 1'b1; // stack push
                bus.addrsel = ADDR_MAR;
            end
            S_LOADD,
            S_STORE4: begin
                bus.cyc        = 1'b1;
                bus.write      = (state == S_STORE4);
                bus.addrsel    = ADDR_MAR;
                bus.byteenable = lanes;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/control_pkg.sv
package control_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [3:0]  exc_t;
    typedef logic [2:0]  ccr_t;      // {ltu, lt, eq}
    typedef logic [3:0]  byte_en_t;
    typedef logic [1:0]  align_t;

    typedef enum logic [3:0] {
        T_INH    = 4'h0,
        T_ALU    = 4'h9,
        T_LDI    = 4'ha,
        T_LOAD   = 4'hb,
        T_STORE  = 4'hc,
        T_BRANCH = 4'hd,
        T_JUMP   = 4'he
    } itype_t;

    localparam logic [3:0] INH_NOP  = 4'h0;
    localparam logic [3:0] INH_TRAP = 4'h1;
    localparam logic [3:0] INH_HALT = 4'h4;

    localparam reg_addr_t REG_SP        = 4'd15;
    localparam exc_t      EXC_RESET     = 4'h0;
    localparam exc_t      EXC_ILLOP     = 4'h2;
    localparam exc_t      EXC_TRAP_BASE = 4'hc; // low two bits from the trap code

    typedef enum logic [5:0] {
        S_RESET, S_EXC, S_EXC2, S_EXC3, S_EXC4, S_EXC5, S_EXC6,
        S_EXC7, S_EXC8, S_EXC9, S_EXC10, S_EXC11, S_EXC12,
        S_FETCH, S_FETCH2, S_EVAL, S_TERM, S_ARG, S_ARG2,
        S_INH, S_HALT, S_MDR2RA, S_LDIU, S_BRANCH,
        S_ALU, S_ALU2, S_ALU3, S_ALU4,
        S_JUMP, S_JUMP2, S_JUMP3,
        S_LOAD, S_LOAD2, S_LOAD3, S_LOADD,
        S_STORE, S_STORE2, S_STORE3, S_STORED, S_STORED2, S_STORE4
    } state_t;

    typedef enum logic [2:0] {
        ALU_AND, ALU_OR, ALU_ADD, ALU_SUB,
        ALU_LSHIFT, ALU_RSHIFTA, ALU_RSHIFTL, ALU_XOR
    } alu_func_t;

    typedef enum logic [1:0] {ALU_B, ALU_SVAL, ALU_4, ALU_1} alu2_sel_t;

    typedef enum logic [2:0] {REG_ALU, REG_MDR, REG_UVAL, REG_B} reg_sel_t;

    typedef enum logic [1:0] {REG_WRITE_NONE = 2'b00, REG_WRITE_DW = 2'b11} reg_write_t;

    typedef enum logic [3:0] {
        MDR_MDR, MDR_BUS, MDR_B, MDR_A, MDR_PC, MDR_INT, MDR_ALU, MDR_CCR
    } mdr_sel_t;

    typedef enum logic [1:0] {MAR_MAR, MAR_BUS, MAR_ALU, MAR_A} mar_sel_t;

    typedef enum logic [1:0] {STATUS_STATUS, STATUS_SUPER, STATUS_POP} status_sel_t;

    typedef enum logic [2:0] {PC_PC, PC_NEXT, PC_MAR, PC_REL, PC_ALU, PC_EXC} pc_sel_t;

    typedef enum logic {ADDR_PC, ADDR_MAR} addr_sel_t;

    typedef struct packed {
        logic        ir_write;
        alu_func_t   alu_func;
        alu2_sel_t   alu2sel;
        reg_sel_t    regsel;
        reg_addr_t   reg_read_addr1;
        reg_addr_t   reg_read_addr2;
        reg_addr_t   reg_write_addr;
        reg_write_t  reg_write;
        logic        a_write;
        logic        b_write;
        mdr_sel_t    mdrsel;
        mar_sel_t    marsel;
        status_sel_t statussel;
        pc_sel_t     pcsel;
    } dp_ctrl_t;

    typedef struct packed {
        logic      cyc;
        logic      write;
        addr_sel_t addrsel;
        byte_en_t  byteenable;
    } bus_req_t;

    typedef struct packed {
        itype_t    itype;
        logic [3:0] op;
        reg_addr_t ra;
        reg_addr_t rb;
        reg_addr_t rc;
        logic      size;      // second word follows
        logic [1:0] trap_code;
        logic      illegal;
    } ir_fields_t;

endpackage

//--- verilog/control_top.sv
`timescale 1ns/1ps

module control_top (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  control_pkg::instr_t   ir,
    input  control_pkg::ccr_t     ccr,
    input  logic                  supervisor,
    input  logic                  bus_ack,
    input  control_pkg::align_t   bus_align,
    output control_pkg::dp_ctrl_t ctrl,
    output control_pkg::bus_req_t bus,
    output control_pkg::exc_t     exception,
    output logic                  halt
);
    import control_pkg::*;

    ir_fields_t fields;
    state_t     state;
    logic       taken;

    ir_decoder i_ir_decoder (
        .ir     (ir),
        .fields (fields)
    );

    sequencer i_sequencer (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .fields     (fields),
        .supervisor (supervisor),
        .bus_ack    (bus_ack),
        .state      (state),
        .exception  (exception),
        .halt       (halt)
    );

    branch_cond i_branch_cond (
        .fields (fields),
        .ccr    (ccr),
        .taken  (taken)
    );

    datapath_ctrl i_datapath_ctrl (
        .state  (state),
        .fields (fields),
        .taken  (taken),
        .ctrl   (ctrl)
    );

    bus_ctrl i_bus_ctrl (
        .state     (state),
        .fields    (fields),
        .bus_align (bus_align),
        .bus       (bus)
    );

endmodule

//--- verilog/datapath_ctrl.sv
`timescale 1ns/1ps

module datapath_ctrl (
    input  control_pkg::state_t     state,
    input  control_pkg::ir_fields_t fields,
    input  logic                    taken,
    output control_pkg::dp_ctrl_t   ctrl
);
    import control_pkg::*;

    always_comb begin
        ctrl.ir_write       = 1'b0;
        ctrl.alu_func       = ALU_ADD;
        ctrl.alu2sel        = ALU_B;
        ctrl.regsel         = REG_ALU;
        ctrl.reg_read_addr1 = fields.ra;
        ctrl.reg_read_addr2 = fields.rb;
        ctrl.reg_write_addr = fields.ra;
        ctrl.reg_write      = REG_WRITE_NONE;
        ctrl.a_write        = 1'b0;
        ctrl.b_write        = 1'b0;
        ctrl.mdrsel         = MDR_MDR;
        ctrl.marsel         = MAR_MAR;
        ctrl.statussel      = STATUS_STATUS;
        ctrl.pcsel          = PC_PC;
        case (state)
            S_EXC: ctrl.statussel = STATUS_SUPER; // selects the ssp
            S_EXC2,
            S_EXC6: begin
                ctrl.a_write        = 1'b1; // A <= SP, unused on reset path
                ctrl.reg_read_addr1 = REG_SP;
                ctrl.mdrsel         = (state == S_EXC2) ? MDR_PC : MDR_CCR;
            end
            S_EXC3,
            S_EXC7: begin
                ctrl.alu2sel  = ALU_4;
                ctrl.alu_func = ALU_SUB;
            end
            S_EXC4,
            S_EXC8: begin
                ctrl.marsel         = MAR_ALU;
                ctrl.reg_write_addr = REG_SP; // SP <= SP - 4
                ctrl.reg_write      = REG_WRITE_DW;
            end
            S_EXC10: ctrl.pcsel = PC_EXC;
            S_EXC11: ctrl.marsel = MAR_BUS;
            S_EXC12: ctrl.pcsel = PC_MAR;
            S_FETCH: ctrl.ir_write = 1'b1;
            S_FETCH2,
            S_ARG2: ctrl.pcsel = PC_NEXT;
            S_ARG: begin
                ctrl.marsel = MAR_BUS;
                ctrl.mdrsel = MDR_BUS;
            end
            S_ALU: begin
                ctrl.reg_read_addr1 = fields.rb;
                ctrl.reg_read_addr2 = fields.rc;
                ctrl.a_write        = 1'b1;
                ctrl.b_write        = 1'b1;
            end
            S_ALU2,
            S_ALU3: begin
                ctrl.alu_func = alu_func_t'(fields.op[2:0]);
                ctrl.alu2sel  = (state == S_ALU3) ? ALU_SVAL : ALU_B;
            end
            S_ALU4: ctrl.mdrsel = MDR_ALU;
            S_MDR2RA: begin
                ctrl.regsel    = REG_MDR; // rA <= MDR
                ctrl.reg_write = REG_WRITE_DW;
            end
            S_LDIU: begin
                ctrl.regsel    = REG_UVAL;
                ctrl.reg_write = REG_WRITE_DW;
            end
            S_BRANCH: ctrl.pcsel = taken ? PC_REL : PC_PC;
            S_JUMP,
            S_LOAD,
            S_STORE: begin
                ctrl.reg_read_addr1 = fields.rb; // A <= rB
                ctrl.a_write        = 1'b1;
            end
            S_JUMP2,
            S_LOAD2: ctrl.alu2sel = ALU_SVAL;
            S_JUMP3: ctrl.pcsel = PC_ALU;
            S_LOAD3: ctrl.marsel = MAR_ALU;
            S_LOADD: ctrl.mdrsel = MDR_BUS;
            S_STORE2: begin
                ctrl.alu2sel = ALU_SVAL;
                ctrl.a_write = 1'b1; // A <= rA
            end
            S_STORE3: begin
                ctrl.marsel = MAR_ALU;
                ctrl.mdrsel = MDR_A;
            end
            S_STORED: ctrl.a_write = 1'b1;
            S_STORED2: ctrl.mdrsel = MDR_A;
            default: ;
        endcase
    end

endmodule

//--- verilog/ir_decoder.sv
`timescale 1ns/1ps

module ir_decoder (
    input  control_pkg::instr_t     ir,
    output control_pkg::ir_fields_t fields
);
    import control_pkg::*;

    itype_t itype;
    logic   inh_ok;

    assign itype  = itype_t'(ir[31:28]);
    assign inh_ok = (ir[27:24] == INH_NOP) || (ir[27:24] == INH_TRAP) ||
                    (ir[27:24] == INH_HALT);

    always_comb begin
        fields.itype     = itype;
        fields.op        = ir[27:24];
        fields.ra        = ir[23:20];
        fields.rb        = ir[19:16];
        fields.rc        = ir[15:12];
        fields.size      = ir[0];
        fields.trap_code = ir[2:1]; // low bits of the unsigned value
        case (itype)
            T_INH: begin
                fields.illegal = !inh_ok;
            end
            T_LDI,
            T_ALU,
            T_LOAD,
            T_STORE,
            T_BRANCH,
            T_JUMP: begin
                fields.illegal = 1'b0;
            end
            default: begin
                fields.illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- verilog/sequencer.sv
`timescale 1ns/1ps

module sequencer (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  control_pkg::ir_fields_t fields,
    input  logic                    supervisor,
    input  logic                    bus_ack,
    output control_pkg::state_t     state,
    output control_pkg::exc_t       exception,
    output logic                    halt
);
    import control_pkg::*;

    state_t state_next;
    exc_t   exception_next;

    assign halt = (state == S_HALT);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state     <= S_RESET;
            exception <= EXC_RESET;
        end else begin
            state     <= state_next;
            exception <= exception_next;
        end
    end

    always_comb begin
        state_next     = state;
        exception_next = exception;
        case (state)
            S_RESET: begin
                exception_next = EXC_RESET;
                state_next     = S_EXC;
            end
            S_EXC:     state_next = S_EXC2;
            S_EXC2:    state_next = (exception == EXC_RESET) ? S_EXC10 : S_EXC3;
            S_EXC3:    state_next = S_EXC4;
            S_EXC4:    state_next = S_EXC5;
            S_EXC5: begin
                if (bus_ack)
                    state_next = S_EXC6; // pc pushed
            end
            S_EXC6:    state_next = S_EXC7;
            S_EXC7:    state_next = S_EXC8;
            S_EXC8:    state_next = S_EXC9;
            S_EXC9: begin
                if (bus_ack)
                    state_next = S_EXC10; // ccr pushed
            end
            S_EXC10:   state_next = S_EXC11;
            S_EXC11: begin
                if (bus_ack)
                    state_next = S_EXC12; // vector in mar
            end
            S_EXC12:   state_next = S_FETCH;
            S_FETCH: begin
                if (bus_ack)
                    state_next = S_FETCH2;
            end
            S_FETCH2:  state_next = S_EVAL;
            S_EVAL: begin
                if (fields.illegal) begin
                    exception_next = EXC_ILLOP;
                    state_next     = S_EXC;
                end else if (fields.size) begin
                    state_next = S_ARG;
                end else begin
                    case (fields.itype)
                        T_INH:    state_next = S_INH;
                        T_LDI:    state_next = S_LDIU;
                        T_ALU:    state_next = S_ALU;
                        T_LOAD:   state_next = S_LOAD;
                        T_STORE:  state_next = S_STORE;
                        T_BRANCH: state_next = S_BRANCH;
                        T_JUMP:   state_next = S_JUMP;
                        default: begin
                            exception_next = EXC_ILLOP;
                            state_next     = S_EXC;
                        end
                    endcase
                end
            end
            S_ARG: begin
                if (bus_ack)
                    state_next = S_ARG2;
            end
            S_ARG2: begin
                case (fields.itype)
                    T_INH:   state_next = S_INH;
                    T_LDI:   state_next = S_MDR2RA;
                    T_LOAD:  state_next = S_LOADD;
                    T_STORE: state_next = S_STORED;
                    T_JUMP:  state_next = S_EXC12; // pc from mar
                    default: begin
                        exception_next = EXC_ILLOP; // alu and branch take no argument
                        state_next     = S_EXC;
                    end
                endcase
            end
            S_INH: begin
                if (fields.op == INH_NOP) begin
                    state_next = S_FETCH;
                end else if (fields.op == INH_TRAP) begin
                    exception_next = EXC_TRAP_BASE | {2'b00, fields.trap_code};
                    state_next     = S_EXC;
                end else if (fields.op == INH_HALT && supervisor) begin
                    state_next = S_HALT;
                end else begin
                    exception_next = EXC_ILLOP;
                    state_next     = S_EXC;
                end
            end
            S_ALU:     state_next = fields.op[3] ? S_ALU3 : S_ALU2;
            S_ALU2,
            S_ALU3:    state_next = S_ALU4;
            S_ALU4:    state_next = S_MDR2RA;
            S_MDR2RA,
            S_LDIU,
            S_BRANCH,
            S_JUMP3,
            S_TERM:    state_next = S_FETCH;
            S_JUMP:    state_next = S_JUMP2;
            S_JUMP2:   state_next = S_JUMP3;
            S_LOAD:    state_next = S_LOAD2;
            S_LOAD2:   state_next = S_LOAD3;
            S_LOAD3:   state_next = S_LOADD;
            S_LOADD: begin
                if (bus_ack)
                    state_next = S_MDR2RA;
            end
            S_STORE:   state_next = S_STORE2;
            S_STORE2:  state_next = S_STORE3;
            S_STORE3:  state_next = S_STORE4;
            S_STORED:  state_next = S_STORED2;
            S_STORED2: state_next = S_STORE4;
            S_STORE4: begin
                if (bus_ack)
                    state_next = S_TERM;
            end
            S_HALT:    state_next = S_HALT; // only reset leaves
            default:   state_next = S_RESET;
        endcase
    end

endmodule
